// ==== verilog/riscv_pkg.sv ====
// Shared word type, data-side operation codes and local memory size; import with riscv::*
package riscv;

    // Machine word used on every memory data path
    typedef logic [31:0] word_t;

    // Data-side operation presented once per cycle
    typedef enum logic [3:0] {
        LOAD_STORE_NONE    = 4'h0, // Idle slot
        LOAD_WORD          = 4'h1,
        LOAD_HALF          = 4'h2, // Sign-extended
        LOAD_BYTE          = 4'h3, // Sign-extended
        LOAD_HALF_UNSIGNED = 4'h4,
        LOAD_BYTE_UNSIGNED = 4'h5,
        STORE_WORD         = 4'h6,
        STORE_HALF         = 4'h7,
        STORE_BYTE         = 4'h8
    } mem_op_t;

    // Word address bits of the local RAM
    localparam int MEM_ADDR_WIDTH = 10;

    // Words in the local RAM
    localparam int MEM_DEPTH = 1 << MEM_ADDR_WIDTH;

endpackage

// ==== verilog/ram.sv ====
// Inferred true dual-port block RAM, byte write enables and read-first registered reads per port
`timescale 1ns/1ps

module ram #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    // Port A
    input  logic                  ena,
    input  logic [3:0]            wea,
    input  logic [ADDR_WIDTH-1:0] addra,
    input  logic [DATA_WIDTH-1:0] dia,
    output logic [DATA_WIDTH-1:0] doa,
    // Port B
    input  logic                  enb,
    input  logic [3:0]            web,
    input  logic [ADDR_WIDTH-1:0] addrb,
    input  logic [DATA_WIDTH-1:0] dib,
    output logic [DATA_WIDTH-1:0] dob
);

    localparam int LANE_WIDTH = DATA_WIDTH / 4; // Four byte lanes per word

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Each port reads the old word and writes its enabled lanes
    always @(posedge clk) begin
        if (ena) begin
            doa <= mem[addra]; // Old contents on a write
            for (int i = 0; i < 4; i++) begin
                if (wea[i]) begin
                    mem[addra][i*LANE_WIDTH +: LANE_WIDTH] <= dia[i*LANE_WIDTH +: LANE_WIDTH];
                end
            end
        end
    end

    always @(posedge clk) begin
        if (enb) begin
            dob <= mem[addrb];
            for (int i = 0; i < 4; i++) begin
                if (web[i]) begin
                    mem[addrb][i*LANE_WIDTH +: LANE_WIDTH] <= dib[i*LANE_WIDTH +: LANE_WIDTH];
                end
            end
        end
    end

endmodule

// ==== verilog/clear_counter.sv ====
// Word address counter that sweeps the RAM once per clear and flags the final word
`timescale 1ns/1ps

module clear_counter import riscv::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clear_en,
    output logic [MEM_ADDR_WIDTH-1:0] clear_addr,
    output logic                      last
);

    localparam logic [MEM_ADDR_WIDTH-1:0] LAST_ADDR = MEM_ADDR_WIDTH'(MEM_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            clear_addr <= '0;
        end else if (clear_en) begin
            clear_addr <= clear_addr + 1'b1; // Wraps to zero after the last word
        end
    end

    assign last = clear_addr == LAST_ADDR;

endmodule

// ==== verilog/clear_fsm.sv ====
// Start-up controller that clears the RAM after reset and then hands it to the core
`timescale 1ns/1ps

module clear_fsm (
    input  logic clk,
    input  logic rst,
    input  logic last,
    output logic clear_en,
    output logic busy
);

    typedef enum logic {
        CLEAR,
        RUN
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CLEAR;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            CLEAR: begin
                if (last) begin
                    state_next = RUN; // Final word written on this edge
                end
            end
            RUN: state_next = RUN; // Left only by reset
            default: state_next = CLEAR;
        endcase
    end

    assign clear_en = state == CLEAR;
    assign busy     = state == CLEAR; // Core must wait

endmodule

// ==== verilog/memory.sv ====
// Local data and instruction memory over one block RAM, with a clear-write path for start-up
`timescale 1ns/1ps

module memory import riscv::*; (
    input  logic                      clk,
    input  logic                      clear_en,
    input  logic [MEM_ADDR_WIDTH-1:0] clear_addr,
    input  mem_op_t                   dmem_op,
    input  word_t                     dmem_addr,
    input  word_t                     dmem_wdata,
    output word_t                     dmem_rdata,
    input  word_t                     imem_addr,
    output word_t                     imem_rdata,
    output logic                      imem_error
);

    // Data operation as seen by the RAM, dropped while clearing
    mem_op_t op;

    assign op = clear_en ? LOAD_STORE_NONE : dmem_op;

    // Store alignment
    word_t      store_data;
    logic [3:0] store_we;

    always_comb begin : store
        // Natural alignment means the byte offset also places halves and words
        store_data = dmem_wdata << {dmem_addr[1:0], 3'b000};
        case (op)
            STORE_WORD: store_we = 4'b1111;
            STORE_HALF: store_we = dmem_addr[1] ? 4'b1100 : 4'b0011;
            STORE_BYTE: store_we = 4'b0001 << dmem_addr[1:0];
            default:    store_we = 4'b0000; // Loads and idle slots
        endcase
    end : store

    // Port A steering between clear and data side
    logic                      ram_ena;
    logic [3:0]                ram_wea;
    logic [MEM_ADDR_WIDTH-1:0] ram_addra;
    word_t                     ram_dia;
    word_t                     ram_doa;

    assign ram_ena   = clear_en || (op != LOAD_STORE_NONE);
    assign ram_wea   = clear_en ? 4'b1111 : store_we;
    assign ram_addra = clear_en ? clear_addr : dmem_addr[MEM_ADDR_WIDTH+1:2];
    assign ram_dia   = clear_en ? '0 : store_data;

    ram #(
        .DATA_WIDTH ($bits(word_t)),
        .ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_ram (
        .clk   (clk),
        .ena   (ram_ena),
        .wea   (ram_wea),
        .addra (ram_addra),
        .dia   (ram_dia),
        .doa   (ram_doa),
        .enb   (1'b1),           // Fetch reads every cycle
        .web   (4'b0000),
        .addrb (imem_addr[MEM_ADDR_WIDTH+1:2]),
        .dib   ('0),
        .dob   (imem_rdata)
    );

    // Fetch must be word aligned
    assign imem_error = |imem_addr[1:0];

    // Load stage, lined up with the registered RAM output
    mem_op_t    load_op;
    logic [1:0] load_addr;

    always_ff @(posedge clk) begin
        load_op   <= op;
        load_addr <= dmem_addr[1:0];
    end

    // Addressed lane moved down to bit 0
    word_t load_shifted;

    assign load_shifted = ram_doa >> {load_addr, 3'b000};

    always_comb begin : load
        case (load_op)
            LOAD_WORD:
                dmem_rdata = ram_doa;
            LOAD_HALF:
                dmem_rdata = {{16{load_shifted[15]}}, load_shifted[15:0]};
            LOAD_BYTE:
                dmem_rdata = {{24{load_shifted[7]}}, load_shifted[7:0]};
            LOAD_HALF_UNSIGNED:
                dmem_rdata = {16'h0000, load_shifted[15:0]};
            LOAD_BYTE_UNSIGNED:
                dmem_rdata = {24'h000000, load_shifted[7:0]};
            default:
                dmem_rdata = 'x; // No load in flight
        endcase
    end : load

endmodule

// ==== verilog/mem_subsystem.sv ====
// Top of the local memory subsystem; clears the RAM after reset, then serves data and fetch
`timescale 1ns/1ps

module mem_subsystem import riscv::*; (
    input  logic    clk,
    input  logic    rst,
    // Data side
    input  mem_op_t dmem_op,
    input  word_t   dmem_addr,
    input  word_t   dmem_wdata,
    output word_t   dmem_rdata,
    // Instruction side
    input  word_t   imem_addr,
    output word_t   imem_rdata,
    output logic    imem_error,
    // High while the clear runs
    output logic    busy
);

    logic                      clear_en;
    logic [MEM_ADDR_WIDTH-1:0] clear_addr;
    logic                      last;

    clear_fsm u_clear_fsm (
        .clk      (clk),
        .rst      (rst),
        .last     (last),
        .clear_en (clear_en),
        .busy     (busy)
    );

    clear_counter u_clear_counter (
        .clk        (clk),
        .rst        (rst),
        .clear_en   (clear_en),
        .clear_addr (clear_addr),
        .last       (last)
    );

    memory u_memory (
        .clk        (clk),
        .clear_en   (clear_en),
        .clear_addr (clear_addr),
        .dmem_op    (dmem_op),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_error (imem_error)
    );

endmodule

// ==== verification/mem_checker.sv ====
// Testbench checker; watches the memory subsystem outputs and compares them with expected values
`timescale 1ns/1ps

module mem_checker import riscv::*; (
    input  logic    clk,
    input  logic    rst,
    input  mem_op_t dmem_op,
    input  word_t   dmem_rdata,
    input  word_t   exp_dmem_rdata,
    input  logic    imem_check,
    input  word_t   imem_rdata,
    input  word_t   exp_imem_rdata,
    input  logic    imem_error,
    input  logic    exp_imem_error,
    output int      check_count,
    output int      error_count
);

    // Expected values lined up with the one-cycle read latency
    logic  load_q;
    word_t exp_dmem_q;
    logic  imem_check_q;
    word_t exp_imem_q;

    function automatic logic is_load(input mem_op_t op);
        case (op)
            LOAD_WORD, LOAD_HALF, LOAD_BYTE,
            LOAD_HALF_UNSIGNED, LOAD_BYTE_UNSIGNED: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic compare_value(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at time %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            load_q       <= 1'b0;
            imem_check_q <= 1'b0;
        end else begin
            load_q       <= is_load(dmem_op);
            imem_check_q <= imem_check;
        end
        exp_dmem_q <= exp_dmem_rdata;
        exp_imem_q <= exp_imem_rdata;
    end

    // Outputs are settled halfway through the cycle
    always @(negedge clk) begin
        if (rst) begin
            check_count = 0;
            error_count = 0;
        end else begin
            if (load_q) begin
                compare_value("dmem_rdata", exp_dmem_q, dmem_rdata);
            end
            if (imem_check_q) begin
                compare_value("imem_rdata", exp_imem_q, imem_rdata);
            end
            if (imem_check) begin
                compare_value("imem_error", {31'b0, exp_imem_error}, {31'b0, imem_error});
            end
        end
    end

endmodule

// ==== verification/mem_tb.sv ====
// Test top for the local memory subsystem; waits out the clear, then replays the stim file
`timescale 1ns/1ps

module mem_tb import riscv::*; ();

    localparam int CLEAR_TIMEOUT = MEM_DEPTH + 64; // Clear cycles plus margin
    localparam int MAX_LINES     = 500;

    logic    clk;
    logic    rst;
    mem_op_t dmem_op;
    word_t   dmem_addr;
    word_t   dmem_wdata;
    word_t   dmem_rdata;
    word_t   imem_addr;
    word_t   imem_rdata;
    logic    imem_error;
    logic    busy;

    // Expected values handed to the checker
    word_t   exp_dmem_rdata;
    word_t   exp_imem_rdata;
    logic    exp_imem_error;
    logic    imem_check;
    int      check_count;
    int      error_count;

    bit      setup_ok;
    int      tests_passed;
    int      tests_failed;
    int      test_checks_start;
    int      test_errors_start;

    mem_subsystem uut (
        .clk        (clk),
        .rst        (rst),
        .dmem_op    (dmem_op),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_error (imem_error),
        .busy       (busy)
    );

    mem_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .dmem_op        (dmem_op),
        .dmem_rdata     (dmem_rdata),
        .exp_dmem_rdata (exp_dmem_rdata),
        .imem_check     (imem_check),
        .imem_rdata     (imem_rdata),
        .exp_imem_rdata (exp_imem_rdata),
        .imem_error     (imem_error),
        .exp_imem_error (exp_imem_error),
        .check_count    (check_count),
        .error_count    (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic string test_name(input int id);
        case (id)
            1: return "clear";
            2: return "word store and load";
            3: return "sub-word stores";
            4: return "sign and zero extension";
            5: return "fetch misalignment";
            6: return "back-to-back";
            default: return "unnamed";
        endcase
    endfunction

    task automatic drive_idle();
        dmem_op        = LOAD_STORE_NONE;
        dmem_addr      = '0;
        dmem_wdata     = '0;
        imem_addr      = '0;
        imem_check     = 1'b0;
        exp_dmem_rdata = '0;
        exp_imem_rdata = '0;
        exp_imem_error = 1'b0;
    endtask

    task automatic wait_for_clear(output bit done);
        int cycles;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < CLEAR_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            done = !busy;
        end
    endtask

    task automatic finish_test(input int id);
        int checks;
        int errors;
        drive_idle();
        @(posedge clk); // Last read of the test is compared before this edge
        #1;
        checks = check_count - test_checks_start;
        errors = error_count - test_errors_start;
        if (errors == 0 && checks > 0) begin
            tests_passed++;
            $display("Test %0d (%s): %0d checks, ok", id, test_name(id), checks);
        end else begin
            tests_failed++;
            $display("Test %0d (%s): %0d checks, %0d errors", id, test_name(id), checks, errors);
        end
    endtask

    task automatic run_stim(input int fd);
        logic [8*128-1:0] line;
        int               lines;
        int               fields;
        int               test_id;
        int               cur_test;
        logic [3:0]       op_val;
        word_t            daddr;
        word_t            wdata;
        word_t            iaddr;
        word_t            exp_d;
        word_t            exp_i;
        logic             icheck_val;
        logic             ierr;
        lines    = 0;
        cur_test = 0;
        while (!$feof(fd) && lines < MAX_LINES) begin
            lines++;
            fields = 0;
            if ($fgets(line, fd) > 0) begin
                fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h", test_id, op_val, daddr,
                                 wdata, iaddr, icheck_val, exp_d, exp_i, ierr);
            end
            if (fields == 9) begin // Comments and blank lines fall through
                if (test_id != cur_test) begin
                    if (cur_test != 0) begin
                        finish_test(cur_test);
                    end
                    cur_test          = test_id;
                    test_checks_start = check_count;
                    test_errors_start = error_count;
                end
                dmem_op        = mem_op_t'(op_val);
                dmem_addr      = daddr;
                dmem_wdata     = wdata;
                imem_addr      = iaddr;
                imem_check     = icheck_val;
                exp_dmem_rdata = exp_d;
                exp_imem_rdata = exp_i;
                exp_imem_error = ierr;
                @(posedge clk);
                #1;
            end
        end
        if (cur_test != 0) begin
            finish_test(cur_test);
        end
        if (lines >= MAX_LINES) begin
            $display("The stimulus file has more lines than the testbench accepts");
            setup_ok = 1'b0;
        end
    endtask

    initial begin
        int fd;
        bit cleared;
        setup_ok          = 1'b1;
        tests_passed      = 0;
        tests_failed      = 0;
        test_checks_start = 0;
        test_errors_start = 0;
        rst               = 1'b1;
        drive_idle();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_for_clear(cleared);
        if (!cleared) begin
            $display("Timeout: busy was still high %0d cycles after reset", CLEAR_TIMEOUT);
            setup_ok = 1'b0;
        end else begin
            fd = $fopen("verification/mem_stim.txt", "r");
            if (fd == 0) begin
                $display("Could not open the stimulus file verification/mem_stim.txt");
                setup_ok = 1'b0;
            end else begin
                run_stim(fd);
                $fclose(fd);
            end
        end
        $display("Tests ok: %0d, tests with errors: %0d, checks: %0d, errors: %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (setup_ok && tests_failed == 0 && error_count == 0 && check_count > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
verilog/riscv_pkg.sv
verilog/ram.sv
verilog/clear_counter.sv
verilog/clear_fsm.sv
verilog/memory.sv
verilog/mem_subsystem.sv
verification/mem_checker.sv
verification/mem_tb.sv

// ==== verification/mem_stim.txt ====
# test op daddr wdata iaddr icheck exp_dmem_rdata exp_imem_rdata exp_imem_error (hex, test in decimal)
# op: 0 none, 1 lw, 2 lh, 3 lb, 4 lhu, 5 lbu, 6 sw, 7 sh, 8 sb
1 1 00000000 00000000 00000000 1 00000000 00000000 0
1 1 00000004 00000000 00000004 1 00000000 00000000 0
1 1 00000404 00000000 00000404 1 00000000 00000000 0
1 1 00000800 00000000 00000800 1 00000000 00000000 0
1 1 00000ffc 00000000 00000ffc 1 00000000 00000000 0
2 6 00000010 12345678 00000000 0 00000000 00000000 0
2 1 00000010 00000000 00000010 1 12345678 12345678 0
2 6 00000ffc cafef00d 00000000 0 00000000 00000000 0
2 1 00000ffc 00000000 00000ffc 1 cafef00d cafef00d 0
2 1 00000000 00000000 00000000 1 00000000 00000000 0
3 6 00000020 11223344 00000000 0 00000000 00000000 0
3 8 00000020 000000aa 00000000 0 00000000 00000000 0
3 1 00000020 00000000 00000020 1 112233aa 112233aa 0
3 8 00000021 123456bb 00000000 0 00000000 00000000 0
3 1 00000020 00000000 00000020 1 1122bbaa 1122bbaa 0
3 8 00000022 000000cc 00000000 0 00000000 00000000 0
3 8 00000023 777777dd 00000000 0 00000000 00000000 0
3 1 00000020 00000000 00000020 1 ddccbbaa ddccbbaa 0
3 6 00000024 55667788 00000000 0 00000000 00000000 0
3 7 00000024 0000beef 00000000 0 00000000 00000000 0
3 1 00000024 00000000 00000024 1 5566beef 5566beef 0
3 7 00000026 9999f00d 00000000 0 00000000 00000000 0
3 1 00000024 00000000 00000024 1 f00dbeef f00dbeef 0
4 6 00000030 80ff7f01 00000000 0 00000000 00000000 0
4 6 00000034 017fc0a5 00000000 0 00000000 00000000 0
4 3 00000030 00000000 00000000 0 00000001 00000000 0
4 3 00000031 00000000 00000000 0 0000007f 00000000 0
4 3 00000032 00000000 00000000 0 ffffffff 00000000 0
4 3 00000033 00000000 00000000 0 ffffff80 00000000 0
4 5 00000030 00000000 00000000 0 00000001 00000000 0
4 5 00000031 00000000 00000000 0 0000007f 00000000 0
4 5 00000032 00000000 00000000 0 000000ff 00000000 0
4 5 00000033 00000000 00000000 0 00000080 00000000 0
4 2 00000030 00000000 00000000 0 00007f01 00000000 0
4 2 00000032 00000000 00000000 0 ffff80ff 00000000 0
4 4 00000030 00000000 00000000 0 00007f01 00000000 0
4 4 00000032 00000000 00000000 0 000080ff 00000000 0
4 3 00000034 00000000 00000000 0 ffffffa5 00000000 0
4 3 00000035 00000000 00000000 0 ffffffc0 00000000 0
4 3 00000036 00000000 00000000 0 0000007f 00000000 0
4 3 00000037 00000000 00000000 0 00000001 00000000 0
4 5 00000034 00000000 00000000 0 000000a5 00000000 0
4 5 00000035 00000000 00000000 0 000000c0 00000000 0
4 5 00000036 00000000 00000000 0 0000007f 00000000 0
4 5 00000037 00000000 00000000 0 00000001 00000000 0
4 2 00000034 00000000 00000000 0 ffffc0a5 00000000 0
4 2 00000036 00000000 00000000 0 0000017f 00000000 0
4 4 00000034 00000000 00000000 0 0000c0a5 00000000 0
4 4 00000036 00000000 00000000 0 0000017f 00000000 0
5 0 00000000 00000000 00000030 1 00000000 80ff7f01 0
5 0 00000000 00000000 00000031 1 00000000 80ff7f01 1
5 0 00000000 00000000 00000032 1 00000000 80ff7f01 1
5 0 00000000 00000000 00000033 1 00000000 80ff7f01 1
5 0 00000000 00000000 00000034 1 00000000 017fc0a5 0
5 0 00000000 00000000 00000036 1 00000000 017fc0a5 1
5 0 00000000 00000000 00000ffe 1 00000000 cafef00d 1
6 6 00000040 a5a5a5a5 00000000 0 00000000 00000000 0
6 1 00000040 00000000 00000000 0 a5a5a5a5 00000000 0
6 8 00000041 0000003c 00000000 0 00000000 00000000 0
6 1 00000040 00000000 00000000 0 a5a53ca5 00000000 0
6 5 00000041 00000000 00000000 0 0000003c 00000000 0
6 7 00000042 00001234 00000000 0 00000000 00000000 0
6 2 00000042 00000000 00000000 0 00001234 00000000 0
6 1 00000040 00000000 00000040 1 12343ca5 12343ca5 0
6 6 00000044 deadbeef 00000000 0 00000000 00000000 0
6 3 00000047 00000000 00000000 0 ffffffde 00000000 0
6 1 00000040 00000000 00000000 0 12343ca5 00000000 0
6 4 00000044 00000000 00000044 1 0000beef deadbeef 0
